//--- common/calcPkg.sv
`default_nettype none

package calcPkg;

    localparam int KeyCount      = 16;
    localparam int ScanLfsrWidth = 6;     // 63 cycles between scan ticks
    localparam int DebounceScans = 3;
    localparam int DebounceWidth = $clog2(DebounceScans + 1);
    localparam int MaxDigits     = 4;
    localparam int DataWidth     = 16;
    localparam int DisplayLimit  = 9999;

    // any nonzero seed works, the tick fires when the state comes back to it
    localparam logic [ScanLfsrWidth-1:0] ScanLfsrSeed = {{(ScanLfsrWidth - 1){1'b0}}, 1'b1};

    typedef enum logic [2:0] {
        opAdd   = 3'd0,
        opSub   = 3'd1,
        opMul   = 3'd2,
        opNeg   = 3'd3,
        opEqual = 3'd4,
        opClear = 3'd5
    } opCode;

    typedef struct packed {
        logic       isOperator;   // zero in this view
        logic [3:0] value;        // 0 to 9
    } digitView;

    typedef struct packed {
        logic  isOperator;        // one in this view
        logic  pad;
        opCode op;
    } operatorView;

    // the top bit tells which view holds
    typedef union packed {
        digitView    digit;
        operatorView oper;
    } keyToken;

    // index is column * 4 + row
    localparam keyToken KeyMap [KeyCount] = '{
        5'h01, 5'h04, 5'h07, {1'b1, 1'b0, opMul},     // column 0: 1 4 7 *
        5'h02, 5'h05, 5'h08, 5'h00,                   // column 1: 2 5 8 0
        5'h03, 5'h06, 5'h09, {1'b1, 1'b0, opNeg},     // column 2: 3 6 9 #
        {1'b1, 1'b0, opAdd},                          // A
        {1'b1, 1'b0, opSub},                          // B
        {1'b1, 1'b0, opEqual},                        // C
        {1'b1, 1'b0, opClear}                         // D
    };

endpackage

`default_nettype wire

//--- rtl/scanTimer.sv
`timescale 1ns/1ns
`default_nettype none

module scanTimer (
    input  logic Clock,
    input  logic Reset,
    output logic ScanTick
);
    import calcPkg::*;

    logic [ScanLfsrWidth-1:0] lfsrState;
    logic                     feedback;

    // x^6 + x^5 + 1, maximal length so every nonzero state is visited
    assign feedback = lfsrState[ScanLfsrWidth-1] ^ lfsrState[ScanLfsrWidth-2];

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            lfsrState <= ScanLfsrSeed;
        end else begin
            lfsrState <= {lfsrState[ScanLfsrWidth-2:0], feedback};   // shift left
        end
    end

    // one pulse per lap of the sequence
    assign ScanTick = (lfsrState == ScanLfsrSeed);

endmodule

`default_nettype wire

//--- keypad/keypadScanner.sv
`timescale 1ns/1ns
`default_nettype none

module keypadScanner (
    input  logic       Clock,
    input  logic       Reset,
    input  logic       ScanTick,
    input  logic [3:0] RowIn,
    output logic [3:0] ColOut,
    output logic       KeyRdy,
    input  logic       KeyRd,
    output logic [3:0] KeyIndex
);
    import calcPkg::*;

    typedef enum logic [1:0] {
        stScan,
        stCheck,
        stWaitRead,
        stWaitRelease
    } scanState;

    scanState                 state;
    logic [1:0]               colIndex;
    logic                     phase;          // second tick of a column samples it
    logic [KeyCount-1:0]      snapshot;       // active low, one bit per key
    logic [KeyCount-1:0]      pressed;
    logic                     oneKey;
    logic [3:0]               foundIndex;
    logic                     walking;
    logic                     scanDone;
    logic [DebounceWidth-1:0] debCount;
    logic [DebounceWidth-1:0] nextCount;

    assign ColOut   = ~(4'b0001 << colIndex);     // active low column drive
    assign walking  = (state == stScan) || (state == stWaitRelease);
    assign scanDone = walking && ScanTick && phase && (colIndex == 2'd3);
    assign pressed  = ~snapshot;
    assign oneKey   = (pressed != '0) && ((pressed & (pressed - 1'b1)) == '0);

    // same key as last scan keeps counting, anything else starts over
    assign nextCount = (debCount != '0 && KeyIndex == foundIndex) ?
                       debCount + 1'b1 : DebounceWidth'(1);

    always_comb begin
        foundIndex = '0;
        for (int i = 0; i < KeyCount; i++) begin
            if (pressed[i]) foundIndex = 4'(i);
        end
    end

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            colIndex <= '0;
            phase    <= 1'b0;
        end else if (walking && ScanTick) begin
            phase <= !phase;
            if (phase) colIndex <= colIndex + 1'b1;   // wraps to column 0
        end
    end

    always_ff @(posedge Clock) begin
        if (walking && ScanTick && phase) snapshot[colIndex*4 +: 4] <= RowIn;
    end

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            state    <= stScan;
            KeyRdy   <= 1'b0;
            KeyIndex <= '0;
            debCount <= '0;
        end else begin
            case (state)
                stScan: begin
                    if (scanDone) state <= stCheck;
                end
                stCheck: begin
                    state <= stScan;
                    if (!oneKey) begin
                        debCount <= '0;
                    end else if (nextCount == DebounceWidth'(DebounceScans)) begin
                        KeyRdy   <= 1'b1;
                        KeyIndex <= foundIndex;
                        debCount <= '0;
                        state    <= stWaitRead;
                    end else begin
                        KeyIndex <= foundIndex;
                        debCount <= nextCount;
                    end
                end
                stWaitRead: begin
                    // scanning stalls until the key is taken
                    if (KeyRd) begin
                        KeyRdy <= 1'b0;
                        state  <= stWaitRelease;
                    end
                end
                default: begin
                    // last nibble lands this edge, so look at RowIn directly
                    if (scanDone && {RowIn, snapshot[KeyCount-5:0]} == '1) state <= stScan;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- keypad/keyDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module keyDecoder (
    input  logic            Clock,
    input  logic            Reset,
    input  logic            KeyRdy,
    input  logic [3:0]      KeyIndex,
    output logic            KeyRd,
    output calcPkg::keyToken Token,
    output logic            TokenValid
);
    import calcPkg::*;

    logic keyTaken;     // high from the read until KeyRdy drops
    logic takeKey;

    assign takeKey = KeyRdy && !keyTaken;

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            keyTaken   <= 1'b0;
            KeyRd      <= 1'b0;
            TokenValid <= 1'b0;
        end else begin
            KeyRd      <= takeKey;          // one-cycle pulses
            TokenValid <= takeKey;
            if (takeKey) begin
                keyTaken <= 1'b1;
            end else if (!KeyRdy) begin
                keyTaken <= 1'b0;           // scanner has let go
            end
        end
    end

    // table lookup, held until the next key
    always_ff @(posedge Clock) begin
        if (takeKey) Token <= KeyMap[KeyIndex];
    end

endmodule

`default_nettype wire

//--- rtl/calcExecute.sv
`timescale 1ns/1ns
`default_nettype none

module calcExecute (
    input  logic                                  Clock,
    input  logic                                  Reset,
    input  calcPkg::keyToken                      Token,
    input  logic                                  TokenValid,
    output logic signed [calcPkg::DataWidth-1:0]  ShowValue,
    output logic                                  KeyAccepted
);
    import calcPkg::*;

    logic signed [DataWidth-1:0] entry;
    logic signed [DataWidth-1:0] accumulator;
    logic signed [DataWidth-1:0] leftOperand;
    logic signed [DataWidth-1:0] digitValue;
    logic [2:0]                  digitCount;
    opCode                       pendingOp;
    logic                        showEntry;
    logic                        leftCleared;    // set after equals

    function automatic logic signed [DataWidth-1:0] applyOp(
        input opCode                       op,
        input logic signed [DataWidth-1:0] lhs,
        input logic signed [DataWidth-1:0] rhs
    );
        case (op)
            opSub:   return lhs - rhs;
            opMul:   return lhs * rhs;     // low half only, wraps
            default: return lhs + rhs;
        endcase
    endfunction

    assign digitValue  = {{(DataWidth - 4){1'b0}}, Token.digit.value};
    assign leftOperand = leftCleared ? '0 : accumulator;
    assign ShowValue   = showEntry ? entry : accumulator;

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            entry       <= '0;
            accumulator <= '0;
            digitCount  <= '0;
            pendingOp   <= opAdd;
            showEntry   <= 1'b0;
            leftCleared <= 1'b0;
            KeyAccepted <= 1'b0;
        end else begin
            KeyAccepted <= TokenValid;
            if (TokenValid && !Token.digit.isOperator) begin
                if (digitCount < 3'(MaxDigits)) begin
                    entry      <= entry * 16'sd10 + digitValue;
                    digitCount <= digitCount + 1'b1;
                    showEntry  <= 1'b1;
                end
            end else if (TokenValid) begin
                case (Token.oper.op)
                    opNeg: begin
                        entry     <= -entry;
                        showEntry <= 1'b1;
                    end
                    opClear: begin
                        entry       <= '0;
                        accumulator <= '0;
                        digitCount  <= '0;
                        pendingOp   <= opAdd;
                        showEntry   <= 1'b0;
                        leftCleared <= 1'b0;
                    end
                    default: begin
                        // add, sub, mul and equal finish the pending operation
                        accumulator <= applyOp(pendingOp, leftOperand, entry);
                        entry       <= '0;
                        digitCount  <= '0;
                        showEntry   <= 1'b0;
                        pendingOp   <= (Token.oper.op == opEqual) ? opAdd : Token.oper.op;
                        leftCleared <= (Token.oper.op == opEqual);   // next sum starts fresh
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/resultFormatter.sv
`timescale 1ns/1ns
`default_nettype none

module resultFormatter (
    input  logic                                 Clock,
    input  logic                                 Reset,
    input  logic signed [calcPkg::DataWidth-1:0] ShowValue,
    output logic [15:0]                          Magnitude,
    output logic                                 Negative,
    output logic                                 Overflow
);
    import calcPkg::*;

    logic                 isNegative;
    logic [DataWidth-1:0] absValue;

    assign isNegative = ShowValue[DataWidth-1];
    // -32768 comes out as 0x8000, still right as unsigned
    assign absValue   = isNegative ? -ShowValue : ShowValue;

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            Magnitude <= '0;
            Negative  <= 1'b0;
            Overflow  <= 1'b0;
        end else begin
            Magnitude <= absValue;
            Negative  <= isNegative;
            Overflow  <= (absValue > DisplayLimit);   // more than four digits
        end
    end

endmodule

`default_nettype wire

//--- rtl/calcTop.sv
`timescale 1ns/1ns
`default_nettype none

module calcTop (
    input  logic        Clock,
    input  logic        Reset,
    input  logic [3:0]  RowIn,
    output logic [3:0]  ColOut,
    output logic [15:0] Magnitude,
    output logic        Negative,
    output logic        Overflow,
    output logic        KeyAccepted
);
    import calcPkg::*;

    logic                        scanTick;
    logic                        keyRdy;
    logic                        keyRd;
    logic [3:0]                  keyIndex;
    keyToken                     token;
    logic                        tokenValid;
    logic signed [DataWidth-1:0] showValue;

    scanTimer uTimer (
        .Clock    (Clock),
        .Reset    (Reset),
        .ScanTick (scanTick)
    );

    keypadScanner uScanner (
        .Clock    (Clock),
        .Reset    (Reset),
        .ScanTick (scanTick),
        .RowIn    (RowIn),
        .ColOut   (ColOut),
        .KeyRdy   (keyRdy),
        .KeyRd    (keyRd),
        .KeyIndex (keyIndex)
    );

    keyDecoder uDecoder (
        .Clock      (Clock),
        .Reset      (Reset),
        .KeyRdy     (keyRdy),
        .KeyIndex   (keyIndex),
        .KeyRd      (keyRd),
        .Token      (token),
        .TokenValid (tokenValid)
    );

    calcExecute uExecute (
        .Clock       (Clock),
        .Reset       (Reset),
        .Token       (token),
        .TokenValid  (tokenValid),
        .ShowValue   (showValue),
        .KeyAccepted (KeyAccepted)
    );

    resultFormatter uFormatter (
        .Clock     (Clock),
        .Reset     (Reset),
        .ShowValue (showValue),
        .Magnitude (Magnitude),
        .Negative  (Negative),
        .Overflow  (Overflow)
    );

endmodule

`default_nettype wire

//--- dv/calcTop_properties.sv
`timescale 1ns/1ns
`default_nettype none

module calcTop_properties (
    input logic Clock,
    input logic Reset,
    input logic KeyRdy,
    input logic KeyRd,
    input logic TokenValid,
    input logic KeyAccepted
);
    int failCount = 0;

    readyHeld: assert property (@(posedge Clock) disable iff (!Reset)
        KeyRdy && !KeyRd |=> KeyRdy)
    else begin
        failCount = failCount + 1;
        $error("KeyRdy dropped before KeyRd");
    end

    // scanner lets go the cycle after the read
    readyDrops: assert property (@(posedge Clock) disable iff (!Reset)
        KeyRd |=> !KeyRdy)
    else begin
        failCount = failCount + 1;
        $error("KeyRdy still high after KeyRd");
    end

    // decoder answers a fresh key with both pulses together
    readWithToken: assert property (@(posedge Clock) disable iff (!Reset)
        $rose(KeyRdy) |=> KeyRd && TokenValid)
    else begin
        failCount = failCount + 1;
        $error("KeyRd and TokenValid differ");
    end

    // a fresh key reaches execute one cycle after its token
    acceptAfterToken: assert property (@(posedge Clock) disable iff (!Reset)
        $rose(KeyRdy) |=> TokenValid ##1 KeyAccepted)
    else begin
        failCount = failCount + 1;
        $error("KeyAccepted does not follow TokenValid");
    end

endmodule

`default_nettype wire

//--- dv/calcTb.sv
`timescale 1ns/1ns
`default_nettype none

module calcTb;
    import calcPkg::*;

    localparam int ClockPeriod  = 20;
    localparam int ResetCycles  = 5;
    localparam int TickCycles   = (1 << ScanLfsrWidth) - 1;
    localparam int ScanCycles   = 8 * TickCycles;         // two ticks per column
    localparam int PressScans   = 4;                      // partial scan plus debounce
    localparam int ReleaseScans = 2;
    localparam int HoldScans    = 3;
    localparam int LineCycles   = 6 * ScanCycles + TickCycles;

    logic        Clock      = 1'b0;
    logic        Reset      = 1'b0;
    logic [3:0]  RowIn;
    logic [3:0]  ColOut;
    logic [15:0] Magnitude;
    logic        Negative;
    logic        Overflow;
    logic        KeyAccepted;

    logic [3:0]  firstKey   = '0;
    logic        firstDown  = 1'b0;
    logic [3:0]  secondKey  = '0;
    logic        secondDown = 1'b0;
    integer      seed       = 32'haa96_94ee;
    int          cycleCount = 0;
    int          cycleLimit = 0;

    logic [7:0]  labels[$];
    int          holds[$];
    int          expMag[$];
    int          expNeg[$];
    int          expOvf[$];

    calcTop dut (.*);

    bind calcTop calcTop_properties props (
        .Clock       (Clock),
        .Reset       (Reset),
        .KeyRdy      (keyRdy),
        .KeyRd       (keyRd),
        .TokenValid  (tokenValid),
        .KeyAccepted (KeyAccepted)
    );

    always #(ClockPeriod / 2) Clock = ~Clock;

    // a pressed key shorts its row to its column while that column is low
    always_comb begin
        RowIn = 4'hF;
        if (firstDown && !ColOut[firstKey[3:2]]) RowIn[firstKey[1:0]] = 1'b0;
        if (secondDown && !ColOut[secondKey[3:2]]) RowIn[secondKey[1:0]] = 1'b0;
    end

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("timeout: no progress after %0d cycles", cycleCount);
            $display("Test failed");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic checkValue(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic abortRun(input string reason);
        $display("%s at %0t ns", reason, $time);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    function automatic int keyIndexOf(input logic [7:0] label);
        string layout = "147*2580369#ABCD";   // column * 4 + row
        for (int i = 0; i < KeyCount; i++) begin
            if (layout[i] == label) return i;
        end
        return -1;
    endfunction

    task automatic waitForAccept();
        do begin
            @(negedge Clock);
        end while (!KeyAccepted);
    endtask

    task automatic watchNoAccept(input int scans, input string what);
        repeat (scans * ScanCycles) begin
            @(negedge Clock);
            if (KeyAccepted) abortRun(what);
        end
    endtask

    task automatic playLine(input int n);
        int idx;
        int delay;
        idx = keyIndexOf(labels[n]);
        if (idx < 0) abortRun("unknown key label in the stimulus file");
        delay = {$random(seed)} % TickCycles;     // vary the scan phase of the press
        repeat (delay + 1) @(posedge Clock);
        firstKey  <= 4'(idx);
        firstDown <= 1'b1;
        if (holds[n] == 2) begin
            secondKey  <= 4'(idx + 4);            // same row, next column
            secondDown <= 1'b1;
            watchNoAccept(PressScans, "a key was accepted while two keys were down");
        end else begin
            waitForAccept();
            repeat (2) @(negedge Clock);
        end
        checkValue("Magnitude", int'(Magnitude), expMag[n]);
        checkValue("Negative", int'(Negative), expNeg[n]);
        checkValue("Overflow", int'(Overflow), expOvf[n]);
        if (holds[n] == 1) watchNoAccept(HoldScans, "a held key was accepted twice");
        @(posedge Clock);
        firstDown  <= 1'b0;
        secondDown <= 1'b0;
        repeat (ReleaseScans * ScanCycles) @(posedge Clock);
    endtask

    initial begin
        int         fd;
        int         holdLines;
        string      line;
        logic [7:0] label;
        int         hold;
        int         mag;
        int         neg;
        int         ovf;
        holdLines = 0;
        fd = $fopen("dv/keys_input.txt", "r");
        if (fd == 0) abortRun("cannot open the key stimulus file");
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line[0] != "/") begin
                if ($sscanf(line, "%c %d %d %d %d", label, hold, mag, neg, ovf) != 5) begin
                    abortRun("malformed line in the key stimulus file");
                end
                labels.push_back(label);
                holds.push_back(hold);
                expMag.push_back(mag);
                expNeg.push_back(neg);
                expOvf.push_back(ovf);
                if (hold == 1) holdLines++;
            end
        end
        $fclose(fd);
        cycleLimit = labels.size() * LineCycles + holdLines * HoldScans * ScanCycles + ScanCycles;

        repeat (ResetCycles) @(posedge Clock);
        Reset <= 1'b1;
        repeat (2) @(negedge Clock);
        checkValue("ColOut", int'(ColOut), 14);   // column 0 low
        checkValue("Magnitude", int'(Magnitude), 0);
        checkValue("Negative", int'(Negative), 0);
        checkValue("Overflow", int'(Overflow), 0);
        checkValue("KeyAccepted", int'(KeyAccepted), 0);

        for (int n = 0; n < labels.size(); n++) begin
            playLine(n);
        end

        if (dut.props.failCount == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("%0d handshake assertions fired during the run", dut.props.failCount);
            $display("Test failed");
            $fatal(1, "handshake assertions failed");
        end
    end

endmodule

`default_nettype wire

//--- dv/keys_input.txt
// key  hold(0 press, 1 long hold, 2 with next-column key)  magnitude  negative  overflow
1 0 1 0 0
2 0 12 0 0
A 0 12 0 0
3 0 3 0 0
0 0 30 0 0
C 0 42 0 0
5 0 5 0 0
B 0 5 0 0
9 0 9 0 0
C 0 4 1 0
7 0 7 0 0
* 0 7 0 0
6 0 6 0 0
C 0 42 0 0
8 1 8 0 0
4 2 8 0 0
4 0 84 0 0
# 0 84 1 0
0 0 840 1 0
0 0 8400 1 0
0 0 8400 1 0
* 0 8400 1 0
3 0 3 0 0
C 0 25200 1 1
D 0 0 0 0

//--- files.f
common/calcPkg.sv
rtl/scanTimer.sv
keypad/keypadScanner.sv
keypad/keyDecoder.sv
rtl/calcExecute.sv
rtl/resultFormatter.sv
rtl/calcTop.sv
dv/calcTop_properties.sv
dv/calcTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module calcTb -f files.f -o calcSim
output=$(./obj_dir/calcSim 2>&1) || true
echo "$output"
echo "$output" | grep -qx "Test passed"
